// ==== Makefile ====
# Verilator build and run for the AXI burst master testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_burst_master
DUT_TOP   ?= axi_burst_master
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
# keep running past assertion failures so the closing report is printed
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
src/axi_burst_pkg.sv
src/xfer_pkg.sv
src/burst_planner.sv
src/wr_burst_engine.sv
src/rd_burst_engine.sv
src/axi_burst_master.sv
tb/axi_burst_master_chk.sv
tb/tb_axi_burst_master.sv

// ==== src/axi_burst_master.sv ====
//////////////////////////////////////////////////
// AXI4 burst master top: write and read engines,
// each with its own planner, running in parallel
//////////////////////////////////////////////////
`timescale 1ns/10ps

module axi_burst_master #(
  parameter int BURST_BYTES = 2048
) (
  input  logic                                 ACLK,
  input  logic                                 ARESETN,
  // command side
  input  xfer_pkg::xfer_cmd_t                  wr_cmd,
  output logic                                 wr_ready,
  output logic                                 wr_done,
  input  xfer_pkg::xfer_cmd_t                  rd_cmd,
  output logic                                 rd_ready,
  output logic                                 rd_done,
  // write FIFO, show-ahead
  input  logic [axi_burst_pkg::AXI_DATA_W-1:0] wr_fifo_data,
  input  logic                                 wr_fifo_empty,
  input  logic                                 wr_fifo_aempty,
  output logic                                 wr_fifo_re,
  // read FIFO
  input  logic                                 rd_fifo_full,
  input  logic                                 rd_fifo_afull,
  output logic                                 rd_fifo_we,
  output logic [axi_burst_pkg::AXI_DATA_W-1:0] rd_fifo_data,
  // AXI master
  output axi_burst_pkg::axi_addr_t             aw,
  input  logic                                 awready,
  output axi_burst_pkg::axi_wdata_t            w,
  input  logic                                 wready,
  input  axi_burst_pkg::axi_bresp_t            b,
  output logic                                 bready,
  output axi_burst_pkg::axi_addr_t             ar,
  input  logic                                 arready,
  input  axi_burst_pkg::axi_rdata_t            r,
  output logic                                 rready,
  // fixed attributes, shared by AW and AR
  output logic [2:0]                           size,
  output logic [1:0]                           burst,
  output logic [3:0]                           cache,
  output axi_burst_pkg::axi_resp_e             wr_status
);
  import axi_burst_pkg::*;
  import xfer_pkg::*;

  // planner handshakes
  logic   wr_load, wr_next;
  logic   rd_load, rd_next;
  burst_t wr_burst, rd_burst;

  assign size  = AXI_SIZE_64;
  assign burst = AXI_BURST_INCR;
  assign cache = AXI_CACHE_DEFAULT;

  //////////////////////////////////////////////////
  // write path
  //////////////////////////////////////////////////
  burst_planner #(
    .BURST_BYTES (BURST_BYTES)
  ) u_wr_planner (
    .ACLK    (ACLK),
    .ARESETN (ARESETN),
    .load    (wr_load),
    .cmd     (wr_cmd),
    .next    (wr_next),
    .burst   (wr_burst)
  );

  wr_burst_engine u_wr_engine (
    .ACLK        (ACLK),
    .ARESETN     (ARESETN),
    .cmd         (wr_cmd),
    .burst       (wr_burst),
    .awready     (awready),
    .wready      (wready),
    .b           (b),
    .fifo_data   (wr_fifo_data),
    .fifo_empty  (wr_fifo_empty),
    .fifo_aempty (wr_fifo_aempty),
    .load        (wr_load),
    .next        (wr_next),
    .aw          (aw),
    .w           (w),
    .bready      (bready),
    .fifo_re     (wr_fifo_re),
    .ready       (wr_ready),
    .done        (wr_done),
    .status      (wr_status)
  );

  //////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////
  burst_planner #(
    .BURST_BYTES (BURST_BYTES)
  ) u_rd_planner (
    .ACLK    (ACLK),
    .ARESETN (ARESETN),
    .load    (rd_load),
    .cmd     (rd_cmd),
    .next    (rd_next),
    .burst   (rd_burst)
  );

  rd_burst_engine u_rd_engine (
    .ACLK       (ACLK),
    .ARESETN    (ARESETN),
    .cmd        (rd_cmd),
    .burst      (rd_burst),
    .arready    (arready),
    .r          (r),
    .fifo_full  (rd_fifo_full),
    .fifo_afull (rd_fifo_afull),
    .load       (rd_load),
    .next       (rd_next),
    .ar         (ar),
    .rready     (rready),
    .fifo_we    (rd_fifo_we),
    .fifo_data  (rd_fifo_data),
    .ready      (rd_ready),
    .done       (rd_done)
  );

endmodule

// ==== src/axi_burst_pkg.sv ====
//////////////////////////////////////////////////
// AXI4 channel types and fixed burst attributes
// shared by the burst engines and the top level
//////////////////////////////////////////////////
package axi_burst_pkg;

  // bus geometry
  localparam int AXI_ADDR_W     = 32;
  localparam int AXI_DATA_W     = 64;
  localparam int AXI_BEAT_BYTES = 8;

  // fixed attributes, every burst is 64-bit incrementing
  localparam logic [2:0] AXI_SIZE_64       = 3'b011;
  localparam logic [1:0] AXI_BURST_INCR    = 2'b01;
  // bufferable, modifiable
  localparam logic [3:0] AXI_CACHE_DEFAULT = 4'b0011;

  // response codes, ordered so that OR keeps the worst one
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // AW and AR share one layout
  typedef struct packed {
    logic                  valid;
    logic [AXI_ADDR_W-1:0] addr;
    logic [7:0]            len;
  } axi_addr_t;

  // W channel
  typedef struct packed {
    logic                      valid;
    logic [AXI_DATA_W-1:0]     data;
    logic [AXI_BEAT_BYTES-1:0] strb;
    logic                      last;
  } axi_wdata_t;

  // R channel
  typedef struct packed {
    logic                  valid;
    logic [AXI_DATA_W-1:0] data;
    axi_resp_e             resp;
    logic                  last;
  } axi_rdata_t;

  // B channel
  typedef struct packed {
    logic      valid;
    axi_resp_e resp;
  } axi_bresp_t;

endpackage

// ==== src/burst_planner.sv ====
//////////////////////////////////////////////////
// splits a transfer into BURST_BYTES sized bursts
// one instance per engine, advanced by next
//////////////////////////////////////////////////
`timescale 1ns/10ps

module burst_planner #(
  parameter int BURST_BYTES = 2048
) (
  input  logic                ACLK,
  input  logic                ARESETN,
  input  logic                load,
  input  xfer_pkg::xfer_cmd_t cmd,
  input  logic                next,
  output xfer_pkg::burst_t    burst
);
  import axi_burst_pkg::*;

  // beats per full burst
  localparam int BEAT_SHIFT  = $clog2(AXI_BEAT_BYTES);
  localparam int BURST_BEATS = BURST_BYTES / AXI_BEAT_BYTES;

  // address of the current burst
  logic [AXI_ADDR_W-1:0] addr_q;
  // remaining bytes minus one, counted from the current burst
  logic [31:0]           rem_q;
  logic                  last_burst;

  //////////////////////////////////////////////////
  // address and remaining length
  //////////////////////////////////////////////////
  always_ff @(posedge ACLK or negedge ARESETN) begin
    if (!ARESETN) begin
      addr_q <= '0;
      rem_q  <= '0;
    end else if (load) begin
      // new transfer from the engine
      addr_q <= cmd.addr;
      rem_q  <= cmd.len - 32'd1;
    end else if (next) begin
      // step past one full burst
      addr_q <= addr_q + AXI_ADDR_W'(BURST_BYTES);
      rem_q  <= rem_q - 32'(BURST_BYTES);
    end
  end

  // rest fits in one burst
  assign last_burst = (rem_q < 32'(BURST_BYTES));

  //////////////////////////////////////////////////
  // descriptor, straight from the registers
  //////////////////////////////////////////////////
  always_comb begin
    burst.addr = addr_q;
    burst.last = last_burst;
    // remainder in beats minus one, always below 256 here
    if (last_burst) begin
      burst.len = 8'(rem_q >> BEAT_SHIFT);
    end else begin
      burst.len = 8'(BURST_BEATS - 1);
    end
  end

endmodule

// ==== src/rd_burst_engine.sv ====
//////////////////////////////////////////////////
// read engine: AR and R handshakes per burst,
// pushes every accepted R beat into the read FIFO
//////////////////////////////////////////////////
`timescale 1ns/10ps

module rd_burst_engine (
  input  logic                                 ACLK,
  input  logic                                 ARESETN,
  input  xfer_pkg::xfer_cmd_t                  cmd,
  input  xfer_pkg::burst_t                     burst,
  input  logic                                 arready,
  input  axi_burst_pkg::axi_rdata_t            r,
  input  logic                                 fifo_full,
  input  logic                                 fifo_afull,
  output logic                                 load,
  output logic                                 next,
  output axi_burst_pkg::axi_addr_t             ar,
  output logic                                 rready,
  output logic                                 fifo_we,
  output logic [axi_burst_pkg::AXI_DATA_W-1:0] fifo_data,
  output logic                                 ready,
  output logic                                 done
);
  import xfer_pkg::*;

  rd_state_e state;
  logic      beat_acc;

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////
  always_ff @(posedge ACLK or negedge ARESETN) begin
    if (!ARESETN) begin
      state <= RD_IDLE;
    end else begin
      case (state)
        RD_IDLE: begin
          if (cmd.start) begin
            state <= RA_WAIT;
          end
        end
        // hold off while the FIFO has little room
        RA_WAIT: begin
          if (!fifo_afull) begin
            state <= RA_START;
          end
        end
        RA_START: state <= RD_WAIT;
        // AR offered here
        RD_WAIT: begin
          if (arready) begin
            state <= RD_PROC;
          end
        end
        // burst ends on RLAST, no local beat count
        RD_PROC: begin
          if (beat_acc && r.last) begin
            state <= burst.last ? RD_DONE : RA_WAIT;
          end
        end
        RD_DONE: state <= RD_IDLE;
        default: state <= RD_IDLE;
      endcase
    end
  end

  // planner control
  assign load = (state == RD_IDLE) && cmd.start;
  assign next = (state == RD_PROC) && beat_acc && r.last && !burst.last;

  // address channel
  always_comb begin
    ar.valid = (state == RD_WAIT);
    ar.addr  = burst.addr;
    ar.len   = burst.len;
  end

  //////////////////////////////////////////////////
  // data path into the FIFO
  //////////////////////////////////////////////////
  // full FIFO stalls the slave, nothing dropped
  assign rready    = !fifo_full;
  assign beat_acc  = r.valid && rready;
  assign fifo_we   = beat_acc;
  assign fifo_data = r.data;

  assign ready = (state == RD_IDLE);
  assign done  = (state == RD_DONE);

endmodule

// ==== src/wr_burst_engine.sv ====
//////////////////////////////////////////////////
// write engine: AW, W and B handshakes per burst,
// pops the show-ahead write FIFO on each W beat
//////////////////////////////////////////////////
`timescale 1ns/10ps

module wr_burst_engine (
  input  logic                                 ACLK,
  input  logic                                 ARESETN,
  input  xfer_pkg::xfer_cmd_t                  cmd,
  input  xfer_pkg::burst_t                     burst,
  input  logic                                 awready,
  input  logic                                 wready,
  input  axi_burst_pkg::axi_bresp_t            b,
  input  logic [axi_burst_pkg::AXI_DATA_W-1:0] fifo_data,
  input  logic                                 fifo_empty,
  input  logic                                 fifo_aempty,
  output logic                                 load,
  output logic                                 next,
  output axi_burst_pkg::axi_addr_t             aw,
  output axi_burst_pkg::axi_wdata_t            w,
  output logic                                 bready,
  output logic                                 fifo_re,
  output logic                                 ready,
  output logic                                 done,
  output axi_burst_pkg::axi_resp_e             status
);
  import axi_burst_pkg::*;
  import xfer_pkg::*;

  wr_state_e  state;
  // beats left in the burst, minus one
  logic [7:0] beat_cnt;
  // W beat offered to the slave
  logic       beat_ok;
  logic       beat_acc;

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////
  always_ff @(posedge ACLK or negedge ARESETN) begin
    if (!ARESETN) begin
      state    <= WR_IDLE;
      beat_cnt <= '0;
      status   <= OKAY;
    end else begin
      case (state)
        WR_IDLE: begin
          if (cmd.start) begin
            state  <= WA_WAIT;
            status <= OKAY;
          end
        end
        // enough data queued, or the tail burst needs no more
        WA_WAIT: begin
          if (!fifo_aempty || burst.last) begin
            state <= WA_START;
          end
        end
        WA_START: begin
          beat_cnt <= burst.len;
          state    <= WD_WAIT;
        end
        // AW offered here
        WD_WAIT: begin
          if (awready) begin
            state <= WD_PROC;
          end
        end
        WD_PROC: begin
          if (beat_acc) begin
            if (beat_cnt == 8'd0) begin
              state <= WR_WAIT;
            end else begin
              beat_cnt <= beat_cnt - 8'd1;
            end
          end
        end
        WR_WAIT: begin
          if (b.valid) begin
            // worst response of the transfer sticks
            status <= axi_resp_e'(status | b.resp);
            state  <= burst.last ? WR_DONE : WA_WAIT;
          end
        end
        WR_DONE: state <= WR_IDLE;
        default: state <= WR_IDLE;
      endcase
    end
  end

  // planner control
  assign load = (state == WR_IDLE) && cmd.start;
  assign next = (state == WR_WAIT) && b.valid && !burst.last;

  // address channel from planner registers, stable while waiting
  always_comb begin
    aw.valid = (state == WD_WAIT);
    aw.addr  = burst.addr;
    aw.len   = burst.len;
  end

  //////////////////////////////////////////////////
  // data channel
  //////////////////////////////////////////////////
  // valid drops while the FIFO runs dry
  assign beat_ok  = (state == WD_PROC) && !fifo_empty;
  assign beat_acc = beat_ok && wready;

  always_comb begin
    w.valid = beat_ok;
    w.data  = fifo_data;
    w.strb  = {AXI_BEAT_BYTES{beat_ok}};
    w.last  = (state == WD_PROC) && (beat_cnt == 8'd0);
  end

  // FIFO pops exactly on the accepted beat
  assign fifo_re = beat_acc;

  // response and status lines
  assign bready = (state == WR_WAIT);
  assign ready  = (state == WR_IDLE);
  assign done   = (state == WR_DONE);

endmodule

// ==== src/xfer_pkg.sv ====
//////////////////////////////////////////////////
// transfer level types: command, burst descriptor
// and the state encodings of both engines
//////////////////////////////////////////////////
package xfer_pkg;

  // one transfer request, len in bytes (multiple of 8)
  typedef struct packed {
    logic                                 start;
    logic [axi_burst_pkg::AXI_ADDR_W-1:0] addr;
    logic [31:0]                          len;
  } xfer_cmd_t;

  // current burst, len is beats minus one
  typedef struct packed {
    logic [axi_burst_pkg::AXI_ADDR_W-1:0] addr;
    logic [7:0]                           len;
    logic                                 last;
  } burst_t;

  // write side
  typedef enum logic [2:0] {
    WR_IDLE, WA_WAIT, WA_START, WD_WAIT, WD_PROC, WR_WAIT, WR_DONE
  } wr_state_e;

  // read side
  typedef enum logic [2:0] {
    RD_IDLE, RA_WAIT, RA_START, RD_WAIT, RD_PROC, RD_DONE
  } rd_state_e;

endpackage

// ==== tb/axi_burst_master_chk.sv ====
//////////////////////////////////////////////////
// AXI protocol assertions for the burst master,
// bound into the top level from the testbench
//////////////////////////////////////////////////
`timescale 1ns/10ps

module axi_burst_master_chk (
  input logic                      ACLK,
  input logic                      ARESETN,
  input axi_burst_pkg::axi_addr_t  aw,
  input logic                      awready,
  input axi_burst_pkg::axi_wdata_t w,
  input logic                      wready,
  input logic                      wr_fifo_re,
  input logic                      wr_done,
  input logic                      rd_done
);
  // failures seen so far, read back by the testbench
  int fail_cnt = 0;

  // AW held until accepted
  a_aw_hold: assert property (@(posedge ACLK) disable iff (!ARESETN)
    aw.valid && !awready |=> aw.valid && $stable(aw.addr) && $stable(aw.len))
    else begin
      $error("aw changed before awready");
      fail_cnt++;
    end

  // W beat held until accepted
  a_w_hold: assert property (@(posedge ACLK) disable iff (!ARESETN)
    w.valid && !wready |=> w.valid && $stable(w.data) && $stable(w.last))
    else begin
      $error("w beat withdrawn or changed before wready");
      fail_cnt++;
    end

  // FIFO pop only on an accepted beat
  a_pop: assert property (@(posedge ACLK) disable iff (!ARESETN)
    wr_fifo_re == (w.valid && wready))
    else begin
      $error("wr_fifo_re differs from accepted W beat");
      fail_cnt++;
    end

  // done strobes are single cycle
  a_wr_done: assert property (@(posedge ACLK) disable iff (!ARESETN)
    wr_done |=> !wr_done)
    else begin
      $error("wr_done longer than one cycle");
      fail_cnt++;
    end

  a_rd_done: assert property (@(posedge ACLK) disable iff (!ARESETN)
    rd_done |=> !rd_done)
    else begin
      $error("rd_done longer than one cycle");
      fail_cnt++;
    end

endmodule

// ==== tb/tb_axi_burst_master.sv ====
//////////////////////////////////////////////////
// testbench for the AXI burst master with a memory slave,
// FIFO models, directed transfer tests and report
//////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_axi_burst_master;
  import axi_burst_pkg::*;
  import xfer_pkg::*;

  localparam int BURST_BYTES = 256;
  localparam int MEM_WORDS   = 2048;
  localparam int TMO_CYCLES  = 5000;
  // write FIFO reports almost-empty below this many words
  localparam int AE_LEVEL    = 8;

  logic        ACLK;
  logic        ARESETN;
  xfer_cmd_t   wr_cmd;
  xfer_cmd_t   rd_cmd;
  logic        wr_ready, wr_done, rd_ready, rd_done;
  logic [63:0] wr_fifo_data;
  logic        wr_fifo_empty, wr_fifo_aempty, wr_fifo_re;
  logic        rd_fifo_full, rd_fifo_afull, rd_fifo_we;
  logic [63:0] rd_fifo_data;
  axi_addr_t   aw, ar;
  axi_wdata_t  w;
  axi_bresp_t  b;
  axi_rdata_t  r;
  logic        awready, wready, arready, bready, rready;
  logic [2:0]  size_attr;
  logic [1:0]  burst_attr;
  logic [3:0]  cache_attr;
  axi_resp_e   wr_status;

  //////////////////////////////////////////////////
  // slave and FIFO model state
  //////////////////////////////////////////////////
  logic [63:0] mem [0:MEM_WORDS-1];
  logic [63:0] wq[$];
  logic [63:0] rq[$];
  // words expected to land in memory
  logic [63:0] wexp[$];
  axi_addr_t   aw_q[$];
  axi_addr_t   ar_q[$];
  integer      seed = 48;
  int          wptr, wbeat, wlen, rptr, rleft, aw_idx, err_burst;
  int          wlast_cnt, wlast_bad, wr_done_cnt, rd_done_cnt;
  int          empty_viol, full_viol;
  int          err_cnt, tmo_cnt, chk_fails;
  logic        stress, empty_hold, full_hold, r_busy, cur_err;
  // handshakes as seen at the falling edge
  logic        aw_fire, w_fire, w_stall, b_fire, ar_fire, r_fire, rd_push, wr_pop;
  axi_addr_t   aw_s, ar_s;
  axi_wdata_t  w_s;
  logic [63:0] rd_word;

  axi_burst_master #(
    .BURST_BYTES (BURST_BYTES)
  ) u_axi_burst_master (
    .ACLK (ACLK), .ARESETN (ARESETN),
    .wr_cmd (wr_cmd), .wr_ready (wr_ready), .wr_done (wr_done),
    .rd_cmd (rd_cmd), .rd_ready (rd_ready), .rd_done (rd_done),
    .wr_fifo_data (wr_fifo_data), .wr_fifo_empty (wr_fifo_empty),
    .wr_fifo_aempty (wr_fifo_aempty), .wr_fifo_re (wr_fifo_re),
    .rd_fifo_full (rd_fifo_full), .rd_fifo_afull (rd_fifo_afull),
    .rd_fifo_we (rd_fifo_we), .rd_fifo_data (rd_fifo_data),
    .aw (aw), .awready (awready), .w (w), .wready (wready),
    .b (b), .bready (bready), .ar (ar), .arready (arready),
    .r (r), .rready (rready),
    .size (size_attr), .burst (burst_attr), .cache (cache_attr),
    .wr_status (wr_status)
  );

  bind axi_burst_master axi_burst_master_chk u_chk (
    .ACLK (ACLK), .ARESETN (ARESETN), .aw (aw), .awready (awready),
    .w (w), .wready (wready), .wr_fifo_re (wr_fifo_re),
    .wr_done (wr_done), .rd_done (rd_done)
  );

  initial begin
    ACLK = 1'b0;
    forever #4 ACLK = ~ACLK;
  end

  //////////////////////////////////////////////////
  // AXI slave, write FIFO and read FIFO models
  //////////////////////////////////////////////////
  initial begin
    awready = 1'b0;
    wready  = 1'b0;
    arready = 1'b0;
    b       = '0;
    r       = '0;
    wr_fifo_data   = '0;
    wr_fifo_empty  = 1'b1;
    wr_fifo_aempty = 1'b1;
    rd_fifo_full   = 1'b0;
    rd_fifo_afull  = 1'b0;
    stress     = 1'b0;
    empty_hold = 1'b0;
    full_hold  = 1'b0;
    r_busy     = 1'b0;
    cur_err    = 1'b0;
    err_burst  = -1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = '0;
    end
    forever begin
      // inputs only move after the rising edge so this is what the edge sees
      @(negedge ACLK);
      aw_s    = aw;
      ar_s    = ar;
      w_s     = w;
      aw_fire = aw.valid && awready;
      w_fire  = w.valid && wready;
      w_stall = w.valid && !wready;
      b_fire  = b.valid && bready;
      ar_fire = ar.valid && arready;
      r_fire  = r.valid && rready;
      wr_pop  = wr_fifo_re;
      rd_push = rd_fifo_we;
      rd_word = rd_fifo_data;
      if (w.valid && wr_fifo_empty) empty_viol++;
      if (rd_fifo_we && rd_fifo_full) full_viol++;
      if (wr_done) wr_done_cnt++;
      if (rd_done) rd_done_cnt++;
      @(posedge ACLK);
      #1;
      // write address of the one burst in flight
      if (aw_fire) begin
        aw_q.push_back(aw_s);
        wptr    = int'(aw_s.addr[13:3]);
        wbeat   = 0;
        wlen    = int'(aw_s.len);
        cur_err = (aw_idx == err_burst);
        aw_idx++;
      end
      if (b_fire) b.valid = 1'b0;
      if (w_fire) begin
        mem[wptr] = w_s.data;
        wptr++;
        if (w_s.last != (wbeat == wlen)) wlast_bad++;
        wbeat++;
        // response follows the last beat
        if (w_s.last) begin
          wlast_cnt++;
          b.valid = 1'b1;
          b.resp  = cur_err ? SLVERR : OKAY;
        end
      end
      if (wr_pop) wq.delete(0);
      // read side
      if (r_fire) begin
        rptr++;
        rleft--;
        if (rleft == 0) r_busy = 1'b0;
      end
      if (ar_fire) begin
        ar_q.push_back(ar_s);
        rptr   = int'(ar_s.addr[13:3]);
        rleft  = int'(ar_s.len) + 1;
        r_busy = 1'b1;
      end
      if (rd_push) rq.push_back(rd_word);
      // R beat held until taken with random gaps between beats
      if (!(r.valid && !r_fire)) begin
        r.valid = r_busy && (($random(seed) & 3) != 0);
        r.data  = mem[rptr % MEM_WORDS];
        r.resp  = OKAY;
        r.last  = (rleft == 1);
      end
      awready = (($random(seed) & 3) != 0);
      wready  = (($random(seed) & 3) != 0);
      arready = (($random(seed) & 3) != 0);
      // stretches of full and empty that never pull a pending W beat
      if (stress) begin
        if (($random(seed) & 7) == 0) full_hold = !full_hold;
        if (!w_stall && (($random(seed) & 3) == 0)) empty_hold = !empty_hold;
      end else begin
        full_hold  = 1'b0;
        empty_hold = 1'b0;
      end
      rd_fifo_full   = full_hold;
      rd_fifo_afull  = full_hold;
      wr_fifo_empty  = (wq.size() == 0) || empty_hold;
      wr_fifo_aempty = (wq.size() < AE_LEVEL);
      wr_fifo_data   = (wq.size() != 0) ? wq[0] : '0;
    end
  end

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////
  task automatic check_word(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input axi_addr_t exp, input axi_addr_t act);
    if (exp !== act) begin
      err_cnt++;
      $display("Error: %s expected addr %h len %0d actual addr %h len %0d",
               name, exp.addr, exp.len, act.addr, act.len);
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
    if (exp !== act) begin
      err_cnt++;
      $display("Error: %s expected %s actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      err_cnt++;
      $display("Error: %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  // preload pattern built from every address bit
  function automatic logic [63:0] fill_word(input logic [31:0] a);
    return {a ^ 32'h5a5a_c3c3, ~a};
  endfunction

  // quiet point of the cycle where nothing else moves
  task automatic settle();
    @(posedge ACLK);
    #3;
  endtask

  task automatic clear_logs(input int bad_burst);
    aw_q.delete();
    ar_q.delete();
    rq.delete();
    wexp.delete();
    aw_idx      = 0;
    err_burst   = bad_burst;
    wlast_cnt   = 0;
    wlast_bad   = 0;
    wr_done_cnt = 0;
    rd_done_cnt = 0;
    empty_viol  = 0;
    full_viol   = 0;
  endtask

  task automatic fill_wfifo(input int words);
    logic [63:0] word;
    for (int i = 0; i < words; i++) begin
      word = {32'($random(seed)), 32'($random(seed))};
      wq.push_back(word);
      wexp.push_back(word);
    end
  endtask

  task automatic preload(input logic [31:0] base, input int words);
    for (int i = 0; i < words; i++) begin
      mem[(int'(base >> 3) + i) % MEM_WORDS] = fill_word(base + 32'(8 * i));
    end
  endtask

  // one-cycle start strobes that may go out together
  task automatic issue_cmds(input logic do_wr, input logic [31:0] wr_addr, input int wr_bytes,
                            input logic do_rd, input logic [31:0] rd_addr, input int rd_bytes);
    @(posedge ACLK);
    #1;
    wr_cmd.start = do_wr;
    wr_cmd.addr  = wr_addr;
    wr_cmd.len   = 32'(wr_bytes);
    rd_cmd.start = do_rd;
    rd_cmd.addr  = rd_addr;
    rd_cmd.len   = 32'(rd_bytes);
    @(posedge ACLK);
    #1;
    wr_cmd.start = 1'b0;
    rd_cmd.start = 1'b0;
  endtask

  task automatic wait_done(input string name, input logic want_wr, input logic want_rd);
    int   cnt;
    logic got_wr;
    logic got_rd;
    cnt    = 0;
    got_wr = !want_wr;
    got_rd = !want_rd;
    while (!(got_wr && got_rd) && cnt < TMO_CYCLES) begin
      @(negedge ACLK);
      if (wr_done) got_wr = 1'b1;
      if (rd_done) got_rd = 1'b1;
      cnt++;
    end
    if (!(got_wr && got_rd)) begin
      tmo_cnt++;
      $display("%s: transfer did not finish within %0d cycles", name, TMO_CYCLES);
    end
    // let the done pulse pass
    repeat (2) @(posedge ACLK);
    #3;
  endtask

  //////////////////////////////////////////////////
  // result checks
  //////////////////////////////////////////////////
  task automatic check_bursts(input string name, input axi_addr_t log_q[$],
                              input logic [31:0] base, input int bytes);
    int        nb;
    int        rem;
    int        i;
    axi_addr_t exp;
    nb = (bytes + BURST_BYTES - 1) / BURST_BYTES;
    check_count({name, " burst count"}, nb, log_q.size());
    for (i = 0; i < nb && i < log_q.size(); i++) begin
      rem       = bytes - i * BURST_BYTES;
      exp.valid = 1'b1;
      exp.addr  = base + 32'(i * BURST_BYTES);
      exp.len   = 8'(((rem >= BURST_BYTES) ? BURST_BYTES : rem) / 8 - 1);
      check_addr({name, " burst"}, exp, log_q[i]);
    end
  endtask

  task automatic check_write_result(input string name, input logic [31:0] base, input int bytes);
    int i;
    check_bursts({name, " aw"}, aw_q, base, bytes);
    check_count({name, " wlast"}, (bytes + BURST_BYTES - 1) / BURST_BYTES, wlast_cnt);
    check_count({name, " misplaced wlast"}, 0, wlast_bad);
    check_count({name, " words left in fifo"}, 0, wq.size());
    check_count({name, " w valid while empty"}, 0, empty_viol);
    check_count({name, " wr_done pulses"}, 1, wr_done_cnt);
    check_count({name, " wr_ready"}, 1, int'(wr_ready));
    for (i = 0; i < bytes / 8; i++) begin
      check_word({name, " memory"}, wexp[i], mem[(int'(base >> 3) + i) % MEM_WORDS]);
    end
  endtask

  task automatic check_read_result(input string name, input logic [31:0] base, input int bytes);
    int i;
    check_bursts({name, " ar"}, ar_q, base, bytes);
    check_count({name, " fifo words"}, bytes / 8, rq.size());
    check_count({name, " push while full"}, 0, full_viol);
    check_count({name, " rd_done pulses"}, 1, rd_done_cnt);
    check_count({name, " rd_ready"}, 1, int'(rd_ready));
    for (i = 0; i < bytes / 8 && i < rq.size(); i++) begin
      check_word({name, " fifo data"}, fill_word(base + 32'(8 * i)), rq[i]);
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////
  task automatic test_reset_state();
    settle();
    check_count("reset outputs low", 0, int'({aw.valid, w.valid, ar.valid, bready,
                wr_done, rd_done, wr_fifo_re, rd_fifo_we}));
    check_count("reset ready levels", 3, int'({wr_ready, rd_ready}));
    check_resp("reset status", OKAY, wr_status);
    // 8-byte beats are size code 3 and INCR is burst code 1
    check_count("size attribute", 3, int'(size_attr));
    check_count("burst attribute", 1, int'(burst_attr));
    check_count("cache attribute", int'(AXI_CACHE_DEFAULT), int'(cache_attr));
  endtask

  task automatic run_write(input string name, input logic [31:0] base, input int bytes,
                           input int bad_burst);
    settle();
    clear_logs(bad_burst);
    fill_wfifo(bytes / 8);
    issue_cmds(1'b1, base, bytes, 1'b0, '0, 0);
    wait_done(name, 1'b1, 1'b0);
    check_write_result(name, base, bytes);
  endtask

  task automatic run_read(input string name, input logic [31:0] base, input int bytes);
    settle();
    clear_logs(-1);
    preload(base, bytes / 8);
    issue_cmds(1'b0, '0, 0, 1'b1, base, bytes);
    wait_done(name, 1'b0, 1'b1);
    check_read_result(name, base, bytes);
  endtask

  task automatic test_error_status();
    // second burst answers SLVERR
    run_write("error write", 32'h0000_2000, 600, 1);
    check_resp("error write status", SLVERR, wr_status);
    run_write("clean write", 32'h0000_2800, 64, -1);
    check_resp("status after error", OKAY, wr_status);
  endtask

  task automatic test_back_pressure();
    settle();
    stress = 1'b1;
    run_write("stalled write", 32'h0000_3000, 600, -1);
    run_read("stalled read", 32'h0000_1000, 600);
    settle();
    stress = 1'b0;
  endtask

  task automatic test_concurrent();
    settle();
    clear_logs(-1);
    fill_wfifo(75);
    preload(32'h0000_1800, 75);
    issue_cmds(1'b1, 32'h0000_0400, 600, 1'b1, 32'h0000_1800, 600);
    wait_done("concurrent", 1'b1, 1'b1);
    check_write_result("concurrent write", 32'h0000_0400, 600);
    check_read_result("concurrent read", 32'h0000_1800, 600);
  endtask

  initial begin
    err_cnt = 0;
    tmo_cnt = 0;
    ARESETN = 1'b0;
    wr_cmd  = '0;
    rd_cmd  = '0;
    repeat (16) @(posedge ACLK);
    #1;
    ARESETN = 1'b1;
    test_reset_state();
    run_write("short write", 32'h0000_0100, 64, -1);
    run_write("multi-burst write", 32'h0000_0800, 600, -1);
    run_read("multi-burst read", 32'h0000_1000, 600);
    test_error_status();
    test_back_pressure();
    test_concurrent();
    chk_fails = u_axi_burst_master.u_chk.fail_cnt;
    $display("summary: %0d check errors, %0d timeouts, %0d assertion failures",
             err_cnt, tmo_cnt, chk_fails);
    if (err_cnt == 0 && tmo_cnt == 0 && chk_fails == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
